/* verilog/sdram_copy_pkg.sv */
package sdram_copy_pkg;

    // bus and beat geometry
    localparam int DATA_W     = 128;  // one beat
    localparam int ADDR_W     = 32;   // byte address
    localparam int BEAT_BYTES = DATA_W / 8;

    // command length, 0 to 2047 beats
    localparam int LEN_W      = 11;

    // avalon burstcount and the burst cap
    localparam int BURST_W    = 11;
    localparam int BURST_MAX  = 16;   // also the fifo depth

    // fifo pointers index BURST_MAX entries
    localparam int FIFO_AW    = 4;

    // command opcodes
    typedef enum logic {
        OP_COPY = 1'b0,   // source run to destination run
        OP_FILL = 1'b1    // pattern to destination run
    } op_t;

endpackage

/* verilog/sdram_read.sv */
module sdram_read
    import sdram_copy_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,

    // avalon-mm read master
    input  wire  [DATA_W-1:0]  readdata,
    input  wire                readdatavalid,
    input  wire                waitrequest,
    output logic               read,
    output logic [ADDR_W-1:0]  address,
    output logic [BURST_W-1:0] burstcount,

    // burst request from the controller
    input  wire  [ADDR_W-1:0]  rd_addr,
    input  wire  [BURST_W-1:0] rd_cnt,
    input  wire                rd_start,
    output logic               read_valid,   // fifo push
    output logic [DATA_W-1:0]  read_data,
    output logic               rd_done       // high while idle
);

    typedef enum logic [1:0] {
        IDLE,
        SEND_ADDR,
        RECV_DATA
    } state_t;

    state_t             state;
    state_t             nxt_state;
    logic [BURST_W-1:0] beats_left;
    logic               beat_dec;

    // request fields, held for the whole burst
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            address    <= '0;
            burstcount <= '0;
        end else if (rd_start && state == IDLE) begin
            address    <= rd_addr;
            burstcount <= rd_cnt;
        end
    end

    // beats still owed by the slave
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            beats_left <= '0;
        else if (rd_start && state == IDLE)
            beats_left <= rd_cnt;
        else if (beat_dec)
            beats_left <= beats_left - BURST_W'(1);
    end

    assign read_data = readdata;  // straight into the fifo

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= nxt_state;
    end

    always_comb begin
        read       = 1'b0;
        read_valid = 1'b0;
        beat_dec   = 1'b0;
        rd_done    = 1'b0;
        nxt_state  = state;

        case (state)
            IDLE: begin
                rd_done = 1'b1;
                if (rd_start)
                    nxt_state = SEND_ADDR;
            end
            SEND_ADDR: begin
                read = 1'b1;  // held until the slave takes it
                if (!waitrequest)
                    nxt_state = RECV_DATA;
            end
            default: begin
                if (readdatavalid) begin
                    read_valid = 1'b1;
                    beat_dec   = 1'b1;
                    if (beats_left == BURST_W'(1))
                        nxt_state = IDLE;  // last beat
                end
            end
        endcase
    end

    // slave must not return data that was never asked for
    a_no_stray_data: assert property (@(posedge clk) disable iff (!rst_n)
        state == IDLE |-> !readdatavalid);

endmodule

/* verilog/sdram_write.sv */
module sdram_write
    import sdram_copy_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,

    // avalon-mm write master
    input  wire                waitrequest,
    output logic               write,
    output logic [ADDR_W-1:0]  address,
    output logic [BURST_W-1:0] burstcount,
    output logic [DATA_W-1:0]  writedata,

    // burst request from the controller
    input  wire  [ADDR_W-1:0]  wr_addr,
    input  wire  [BURST_W-1:0] wr_cnt,
    input  wire                wr_fill,
    input  wire  [DATA_W-1:0]  fill_data,
    input  wire  [DATA_W-1:0]  fifo_data,  // show-ahead head
    input  wire                wr_start,
    output logic               beat_take,
    output logic               wr_done     // high while idle
);

    typedef enum logic {
        IDLE,
        SEND_DATA
    } state_t;

    state_t             state;
    logic [BURST_W-1:0] beats_left;
    logic               fill_q;
    logic [DATA_W-1:0]  pattern_q;
    logic               accept;

    assign accept = (state == SEND_DATA) && !waitrequest;

    // burst header, fixed from the first beat on
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            address    <= '0;
            burstcount <= '0;
            fill_q     <= 1'b0;
        end else if (wr_start && state == IDLE) begin
            address    <= wr_addr;
            burstcount <= wr_cnt;
            fill_q     <= wr_fill;
        end
    end

    // fill pattern, payload only
    always_ff @(posedge clk) begin
        if (wr_start && state == IDLE)
            pattern_q <= fill_data;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            beats_left <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_start) begin
                        state      <= SEND_DATA;
                        beats_left <= wr_cnt;
                    end
                end
                default: begin
                    if (accept) begin
                        beats_left <= beats_left - BURST_W'(1);
                        if (beats_left == BURST_W'(1))
                            state <= IDLE;  // last beat taken
                    end
                end
            endcase
        end
    end

    assign write     = (state == SEND_DATA);
    assign writedata = fill_q ? pattern_q : fifo_data;
    assign beat_take = accept;
    assign wr_done   = (state == IDLE);

    // fifo head must not move under a stalled beat
    a_data_held: assert property (@(posedge clk) disable iff (!rst_n)
        (write && waitrequest) |=> (write && $stable(writedata)));

endmodule

/* verilog/beat_fifo.sv */
module beat_fifo
    import sdram_copy_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               push,
    input  wire  [DATA_W-1:0] push_data,
    input  wire               pop,
    output logic [DATA_W-1:0] pop_data,  // head, valid when not empty
    output logic              empty,
    output logic              full
);

    localparam logic [FIFO_AW:0] DEPTH = (FIFO_AW + 1)'(BURST_MAX);

    logic [DATA_W-1:0]  mem [BURST_MAX];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    // pointers wrap on their own at depth 16
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + FIFO_AW'(1);
            if (pop)
                rd_ptr <= rd_ptr + FIFO_AW'(1);
            case ({push, pop})
                2'b10:   count <= count + (FIFO_AW + 1)'(1);
                2'b01:   count <= count - (FIFO_AW + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    assign pop_data = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == DEPTH);

    // bursts are capped at the depth, so neither should ever fire
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) full |-> !push);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) empty |-> !pop);

endmodule

/* verilog/copy_ctrl.sv */
module copy_ctrl
    import sdram_copy_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,

    // command side
    input  wire                cmd_start,
    input  op_t                cmd_op,
    input  wire  [ADDR_W-1:0]  cmd_src,
    input  wire  [ADDR_W-1:0]  cmd_dst,
    input  wire  [LEN_W-1:0]   cmd_len,
    output logic               busy,
    output logic               cmd_done,

    // read master
    output logic               rd_start,
    output logic [ADDR_W-1:0]  rd_addr,
    output logic [BURST_W-1:0] rd_cnt,
    input  wire                rd_done,

    // write master
    output logic               wr_start,
    output logic [ADDR_W-1:0]  wr_addr,
    output logic [BURST_W-1:0] wr_cnt,
    output logic               wr_fill,
    input  wire                wr_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHUNK,
        S_RD_START,
        S_RD_WAIT,
        S_WR_START,
        S_WR_WAIT,
        S_DONE
    } state_t;

    state_t             state;
    op_t                op_q;
    logic [ADDR_W-1:0]  src_q;
    logic [ADDR_W-1:0]  dst_q;
    logic [LEN_W-1:0]   remain_q;
    logic [BURST_W-1:0] chunk_q;
    logic [ADDR_W-1:0]  chunk_bytes;
    logic               accept;

    // idle and done both count as not busy
    assign busy   = (state != S_IDLE) && (state != S_DONE);
    assign accept = cmd_start && !busy;

    assign chunk_bytes = ADDR_W'(chunk_q) * ADDR_W'(BEAT_BYTES);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            op_q     <= OP_COPY;
            src_q    <= '0;
            dst_q    <= '0;
            remain_q <= '0;
            chunk_q  <= '0;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    state <= S_IDLE;
                    if (accept) begin
                        state    <= S_CHUNK;
                        op_q     <= cmd_op;
                        src_q    <= cmd_src;
                        dst_q    <= cmd_dst;
                        remain_q <= cmd_len;
                    end
                end
                S_CHUNK: begin
                    if (remain_q == '0) begin
                        state <= S_DONE;
                    end else begin
                        // min(remaining, burst cap)
                        if (remain_q > LEN_W'(BURST_MAX))
                            chunk_q <= BURST_W'(BURST_MAX);
                        else
                            chunk_q <= BURST_W'(remain_q);
                        state <= (op_q == OP_FILL) ? S_WR_START : S_RD_START;
                    end
                end
                S_RD_START: state <= S_RD_WAIT;
                S_RD_WAIT: begin
                    if (rd_done) begin  // whole chunk sits in the fifo
                        src_q <= src_q + chunk_bytes;
                        state <= S_WR_START;
                    end
                end
                S_WR_START: state <= S_WR_WAIT;
                S_WR_WAIT: begin
                    if (wr_done) begin
                        dst_q    <= dst_q + chunk_bytes;
                        remain_q <= remain_q - LEN_W'(chunk_q);
                        state    <= S_CHUNK;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign cmd_done = (state == S_DONE);

    assign rd_start = (state == S_RD_START);
    assign rd_addr  = src_q;
    assign rd_cnt   = chunk_q;

    assign wr_start = (state == S_WR_START);
    assign wr_addr  = dst_q;
    assign wr_cnt   = chunk_q;
    assign wr_fill  = (op_q == OP_FILL);  // steady for the whole command

endmodule

/* verilog/sdram_copy_top.sv */
module sdram_copy_top
    import sdram_copy_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,

    // command side
    input  wire                cmd_start,
    input  op_t                cmd_op,
    input  wire  [ADDR_W-1:0]  cmd_src,
    input  wire  [ADDR_W-1:0]  cmd_dst,
    input  wire  [LEN_W-1:0]   cmd_len,
    input  wire  [DATA_W-1:0]  fill_data,
    output logic               busy,
    output logic               cmd_done,

    // avalon-mm read port
    output logic               avm_rd_read,
    output logic [ADDR_W-1:0]  avm_rd_address,
    output logic [BURST_W-1:0] avm_rd_burstcount,
    input  wire  [DATA_W-1:0]  avm_rd_readdata,
    input  wire                avm_rd_readdatavalid,
    input  wire                avm_rd_waitrequest,

    // avalon-mm write port
    output logic               avm_wr_write,
    output logic [ADDR_W-1:0]  avm_wr_address,
    output logic [BURST_W-1:0] avm_wr_burstcount,
    output logic [DATA_W-1:0]  avm_wr_writedata,
    input  wire                avm_wr_waitrequest
);

    logic               rd_start;
    logic [ADDR_W-1:0]  rd_addr;
    logic [BURST_W-1:0] rd_cnt;
    logic               rd_done;
    logic               wr_start;
    logic [ADDR_W-1:0]  wr_addr;
    logic [BURST_W-1:0] wr_cnt;
    logic               wr_fill;
    logic               wr_done;
    logic               read_valid;
    logic [DATA_W-1:0]  read_data;
    logic [DATA_W-1:0]  fifo_data;
    logic               beat_take;
    logic               fifo_pop;

    assign fifo_pop = beat_take && !wr_fill;  // fill beats never touch the fifo

    copy_ctrl i_copy_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_start (cmd_start),
        .cmd_op    (cmd_op),
        .cmd_src   (cmd_src),
        .cmd_dst   (cmd_dst),
        .cmd_len   (cmd_len),
        .busy      (busy),
        .cmd_done  (cmd_done),
        .rd_start  (rd_start),
        .rd_addr   (rd_addr),
        .rd_cnt    (rd_cnt),
        .rd_done   (rd_done),
        .wr_start  (wr_start),
        .wr_addr   (wr_addr),
        .wr_cnt    (wr_cnt),
        .wr_fill   (wr_fill),
        .wr_done   (wr_done)
    );

    sdram_read i_sdram_read (
        .clk           (clk),
        .rst_n         (rst_n),
        .readdata      (avm_rd_readdata),
        .readdatavalid (avm_rd_readdatavalid),
        .waitrequest   (avm_rd_waitrequest),
        .read          (avm_rd_read),
        .address       (avm_rd_address),
        .burstcount    (avm_rd_burstcount),
        .rd_addr       (rd_addr),
        .rd_cnt        (rd_cnt),
        .rd_start      (rd_start),
        .read_valid    (read_valid),
        .read_data     (read_data),
        .rd_done       (rd_done)
    );

    beat_fifo i_beat_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (read_valid),
        .push_data (read_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (),
        .full      ()
    );

    sdram_write i_sdram_write (
        .clk         (clk),
        .rst_n       (rst_n),
        .waitrequest (avm_wr_waitrequest),
        .write       (avm_wr_write),
        .address     (avm_wr_address),
        .burstcount  (avm_wr_burstcount),
        .writedata   (avm_wr_writedata),
        .wr_addr     (wr_addr),
        .wr_cnt      (wr_cnt),
        .wr_fill     (wr_fill),
        .fill_data   (fill_data),
        .fifo_data   (fifo_data),
        .wr_start    (wr_start),
        .beat_take   (beat_take),
        .wr_done     (wr_done)
    );

endmodule

/* testbench/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // period 10
    end

    // reset held for 8 cycles, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* testbench/avm_mem_model.sv */
module avm_mem_model
    import sdram_copy_pkg::*;
#(
    parameter int DEPTH = 1024  // beats
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                stall_en,  // random waitrequest and data gaps

    // read slave
    input  wire                rd_read,
    input  wire  [ADDR_W-1:0]  rd_address,
    input  wire  [BURST_W-1:0] rd_burstcount,
    output logic [DATA_W-1:0]  rd_readdata,
    output logic               rd_readdatavalid,
    output logic               rd_waitrequest,

    // write slave
    input  wire                wr_write,
    input  wire  [ADDR_W-1:0]  wr_address,
    input  wire  [BURST_W-1:0] wr_burstcount,
    input  wire  [DATA_W-1:0]  wr_writedata,
    output logic               wr_waitrequest
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [ADDR_W-1:0] rd_base;
    int                rd_beat;
    int                rd_left;   // beats still owed to the master
    int                rd_delay;
    int                wr_beat;   // position inside the write burst

    function automatic logic [IDX_W-1:0] beat_index(input logic [ADDR_W-1:0] addr,
                                                    input int ofs);
        return IDX_W'(int'(addr / ADDR_W'(BEAT_BYTES)) + ofs);
    endfunction

    // power-up content, every field tied to the beat index
    function automatic logic [DATA_W-1:0] init_beat(input int i);
        return {32'h5a5a_0000 ^ i, ~i, i * 32'h9e37_79b9, 32'h0f1e_2d3c + i};
    endfunction

    always @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++)
                mem[IDX_W'(i)] = init_beat(i);
            rd_readdata      <= '0;
            rd_readdatavalid <= 1'b0;
            rd_waitrequest   <= 1'b0;
            wr_waitrequest   <= 1'b0;
            rd_base          <= '0;
            rd_beat          <= 0;
            rd_left          <= 0;
            rd_delay         <= 0;
            wr_beat          <= 0;
        end else begin
            rd_waitrequest   <= stall_en && ($urandom_range(3) == 0);
            wr_waitrequest   <= stall_en && ($urandom_range(3) == 0);
            rd_readdatavalid <= 1'b0;

            if (rd_read && !rd_waitrequest && rd_left == 0) begin
                rd_base  <= rd_address;
                rd_beat  <= 0;
                rd_left  <= int'(rd_burstcount);
                rd_delay <= int'($urandom_range(4, 1));  // 1 to 4 cycles
            end else if (rd_left > 0) begin
                if (rd_delay > 1) begin
                    rd_delay <= rd_delay - 1;
                end else if (!stall_en || $urandom_range(3) != 0) begin
                    rd_readdatavalid <= 1'b1;
                    rd_readdata      <= mem[beat_index(rd_base, rd_beat)];
                    rd_beat          <= rd_beat + 1;
                    rd_left          <= rd_left - 1;
                end
            end

            if (wr_write && !wr_waitrequest) begin
                mem[beat_index(wr_address, wr_beat)] = wr_writedata;
                wr_beat <= (wr_beat + 1 == int'(wr_burstcount)) ? 0 : wr_beat + 1;
            end
        end
    end

endmodule

/* testbench/tb_sdram_copy.sv */
module tb_sdram_copy
    import sdram_copy_pkg::*;
();

    localparam int MEM_BEATS    = 1024;
    localparam int MEM_AW       = 10;
    localparam int DONE_TIMEOUT = 2000;  // cycles

    logic               clk;
    logic               rst_n;
    logic               stall_en;
    logic               cmd_start;
    op_t                cmd_op;
    logic [ADDR_W-1:0]  cmd_src;
    logic [ADDR_W-1:0]  cmd_dst;
    logic [LEN_W-1:0]   cmd_len;
    logic [DATA_W-1:0]  fill_data;
    logic               busy;
    logic               cmd_done;
    logic               avm_rd_read;
    logic [ADDR_W-1:0]  avm_rd_address;
    logic [BURST_W-1:0] avm_rd_burstcount;
    logic [DATA_W-1:0]  avm_rd_readdata;
    logic               avm_rd_readdatavalid;
    logic               avm_rd_waitrequest;
    logic               avm_wr_write;
    logic [ADDR_W-1:0]  avm_wr_address;
    logic [BURST_W-1:0] avm_wr_burstcount;
    logic [DATA_W-1:0]  avm_wr_writedata;
    logic               avm_wr_waitrequest;

    logic [DATA_W-1:0]  shadow [MEM_BEATS];  // expected memory
    logic [ADDR_W-1:0]  rd_addr_log [$];
    logic [BURST_W-1:0] rd_cnt_log [$];
    logic [ADDR_W-1:0]  wr_addr_log [$];
    logic [BURST_W-1:0] wr_cnt_log [$];
    int                 wr_beats_seen;
    int                 wr_beat_mon = 0;

    tb_clk_gen i_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    avm_mem_model #(.DEPTH(MEM_BEATS)) i_mem_model (
        .clk              (clk),
        .rst_n            (rst_n),
        .stall_en         (stall_en),
        .rd_read          (avm_rd_read),
        .rd_address       (avm_rd_address),
        .rd_burstcount    (avm_rd_burstcount),
        .rd_readdata      (avm_rd_readdata),
        .rd_readdatavalid (avm_rd_readdatavalid),
        .rd_waitrequest   (avm_rd_waitrequest),
        .wr_write         (avm_wr_write),
        .wr_address       (avm_wr_address),
        .wr_burstcount    (avm_wr_burstcount),
        .wr_writedata     (avm_wr_writedata),
        .wr_waitrequest   (avm_wr_waitrequest)
    );

    sdram_copy_top i_sdram_copy_top (
        .clk                  (clk),
        .rst_n                (rst_n),
        .cmd_start            (cmd_start),
        .cmd_op               (cmd_op),
        .cmd_src              (cmd_src),
        .cmd_dst              (cmd_dst),
        .cmd_len              (cmd_len),
        .fill_data            (fill_data),
        .busy                 (busy),
        .cmd_done             (cmd_done),
        .avm_rd_read          (avm_rd_read),
        .avm_rd_address       (avm_rd_address),
        .avm_rd_burstcount    (avm_rd_burstcount),
        .avm_rd_readdata      (avm_rd_readdata),
        .avm_rd_readdatavalid (avm_rd_readdatavalid),
        .avm_rd_waitrequest   (avm_rd_waitrequest),
        .avm_wr_write         (avm_wr_write),
        .avm_wr_address       (avm_wr_address),
        .avm_wr_burstcount    (avm_wr_burstcount),
        .avm_wr_writedata     (avm_wr_writedata),
        .avm_wr_waitrequest   (avm_wr_waitrequest)
    );

    // log every burst header the slaves accept
    always @(posedge clk) begin
        if (rst_n && avm_rd_read && !avm_rd_waitrequest) begin
            rd_addr_log.push_back(avm_rd_address);
            rd_cnt_log.push_back(avm_rd_burstcount);
        end
        if (rst_n && avm_wr_write && !avm_wr_waitrequest) begin
            if (wr_beat_mon == 0) begin  // first beat carries the header
                wr_addr_log.push_back(avm_wr_address);
                wr_cnt_log.push_back(avm_wr_burstcount);
            end
            wr_beats_seen++;
            wr_beat_mon = (wr_beat_mon + 1 == int'(avm_wr_burstcount)) ? 0 : wr_beat_mon + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_beat(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("ERR %s got=%h exp=%h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("ERR %s got=%h exp=%h", name, got, exp));
    endtask

    task automatic check_count(input string name, input logic [BURST_W-1:0] got,
                               input logic [BURST_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("ERR %s got=%h exp=%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("ERR %s got=%h exp=%h", name, got, exp));
    endtask

    function automatic logic [MEM_AW-1:0] beat_of(input logic [ADDR_W-1:0] addr,
                                                 input int ofs);
        return MEM_AW'(int'(addr / ADDR_W'(BEAT_BYTES)) + ofs);
    endfunction

    task automatic snapshot();
        for (int i = 0; i < MEM_BEATS; i++)
            shadow[MEM_AW'(i)] = i_mem_model.mem[MEM_AW'(i)];
    endtask

    task automatic apply_copy(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                              input int len);
        for (int i = 0; i < len; i++)
            shadow[beat_of(dst, i)] = shadow[beat_of(src, i)];
    endtask

    task automatic apply_fill(input logic [ADDR_W-1:0] dst, input int len,
                              input logic [DATA_W-1:0] pattern);
        for (int i = 0; i < len; i++)
            shadow[beat_of(dst, i)] = pattern;
    endtask

    task automatic compare_mem();
        for (int i = 0; i < MEM_BEATS; i++)
            check_beat($sformatf("mem[%0d]", i), i_mem_model.mem[MEM_AW'(i)],
                       shadow[MEM_AW'(i)]);
    endtask

    task automatic clear_log();
        rd_addr_log.delete();
        rd_cnt_log.delete();
        wr_addr_log.delete();
        wr_cnt_log.delete();
        wr_beats_seen = 0;
    endtask

    // bursts of min(remaining, BURST_MAX), address stepping by the beats sent
    task automatic check_bursts(input bit rd_port, input logic [ADDR_W-1:0] base,
                                input int len);
        int                 n_exp;
        int                 n_got;
        int                 left;
        string              addr_name;
        string              cnt_name;
        logic [ADDR_W-1:0]  exp_addr;
        logic [BURST_W-1:0] exp_cnt;
        n_exp = (len + BURST_MAX - 1) / BURST_MAX;
        if (rd_port) begin
            n_got     = rd_addr_log.size();
            addr_name = "avm_rd_address";
            cnt_name  = "avm_rd_burstcount";
        end else begin
            n_got     = wr_addr_log.size();
            addr_name = "avm_wr_address";
            cnt_name  = "avm_wr_burstcount";
        end
        if (n_got != n_exp)
            abort_run($sformatf("%s port saw %0d bursts instead of %0d",
                                rd_port ? "read" : "write", n_got, n_exp));
        exp_addr = base;
        left     = len;
        for (int k = 0; k < n_exp; k++) begin
            exp_cnt = BURST_W'((left > BURST_MAX) ? BURST_MAX : left);
            if (rd_port) begin
                check_addr(addr_name, rd_addr_log[k], exp_addr);
                check_count(cnt_name, rd_cnt_log[k], exp_cnt);
            end else begin
                check_addr(addr_name, wr_addr_log[k], exp_addr);
                check_count(cnt_name, wr_cnt_log[k], exp_cnt);
            end
            exp_addr = exp_addr + ADDR_W'(int'(exp_cnt) * BEAT_BYTES);
            left     = left - int'(exp_cnt);
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (!rst_n && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n)
            abort_run("reset was never released");
    endtask

    task automatic drive_start(input op_t op, input logic [ADDR_W-1:0] src,
                               input logic [ADDR_W-1:0] dst, input int len,
                               input logic [DATA_W-1:0] pattern);
        @(posedge clk);
        #1;
        cmd_op    = op;
        cmd_src   = src;
        cmd_dst   = dst;
        cmd_len   = LEN_W'(len);
        fill_data = pattern;  // held until the next command
        cmd_start = 1'b1;
        @(posedge clk);
        #1;
        cmd_start = 1'b0;
    endtask

    // cycles counts edges after the one that took the start pulse
    task automatic wait_done(output int cycles);
        bit seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cmd_done) begin
                seen = 1'b1;
                check_bit("busy", busy, 1'b0);
            end
        end
        if (!seen)
            abort_run($sformatf("no cmd_done within %0d cycles", DONE_TIMEOUT));
    endtask

    task automatic run_cmd(input op_t op, input logic [ADDR_W-1:0] src,
                           input logic [ADDR_W-1:0] dst, input int len,
                           input logic [DATA_W-1:0] pattern, output int cycles);
        clear_log();
        drive_start(op, src, dst, len, pattern);
        check_bit("busy", busy, 1'b1);  // rises after the accepted start
        wait_done(cycles);
    endtask

    task automatic test_reset();
        $display("reset values");
        check_bit("busy", busy, 1'b0);
        check_bit("cmd_done", cmd_done, 1'b0);
        check_bit("avm_rd_read", avm_rd_read, 1'b0);
        check_bit("avm_wr_write", avm_wr_write, 1'b0);
    endtask

    task automatic test_single_copy();
        int cycles;
        $display("single-burst copy");
        stall_en = 1'b0;
        snapshot();
        apply_copy(32'h0000_0000, 32'h0000_1000, 8);
        run_cmd(OP_COPY, 32'h0000_0000, 32'h0000_1000, 8, '0, cycles);
        check_bursts(1'b1, 32'h0000_0000, 8);
        check_bursts(1'b0, 32'h0000_1000, 8);
        compare_mem();
    endtask

    task automatic test_multi_copy();
        int cycles;
        $display("multi-chunk copy with stalls");
        stall_en = 1'b1;
        snapshot();
        apply_copy(32'h0000_2000, 32'h0000_3000, 37);
        run_cmd(OP_COPY, 32'h0000_2000, 32'h0000_3000, 37, '0, cycles);
        check_bursts(1'b1, 32'h0000_2000, 37);  // 16, 16, 5
        check_bursts(1'b0, 32'h0000_3000, 37);
        compare_mem();
    endtask

    task automatic test_fill();
        int                cycles;
        logic [DATA_W-1:0] pattern;
        $display("fill");
        pattern  = 128'hc0de_0001_89ab_cdef_fedc_ba98_7654_3210;
        stall_en = 1'b1;
        snapshot();
        apply_fill(32'h0000_0800, 20, pattern);
        run_cmd(OP_FILL, 32'h0000_0000, 32'h0000_0800, 20, pattern, cycles);
        if (rd_addr_log.size() != 0)
            abort_run("fill command issued a read request");
        check_bursts(1'b0, 32'h0000_0800, 20);  // 16 then 4
        compare_mem();
    endtask

    task automatic test_zero_len();
        int cycles;
        $display("zero-length command");
        snapshot();
        run_cmd(OP_COPY, 32'h0000_0100, 32'h0000_0200, 0, '0, cycles);
        // start raised one cycle, done two cycles later
        if (cycles != 1)
            abort_run($sformatf("zero-length command done %0d cycles late", cycles - 1));
        if (rd_addr_log.size() != 0 || wr_beats_seen != 0)
            abort_run("zero-length command caused memory traffic");
        compare_mem();
    endtask

    task automatic test_start_while_busy();
        int cycles;
        int beats_at_done;
        $display("start while busy");
        stall_en = 1'b1;
        snapshot();
        apply_copy(32'h0000_1000, 32'h0000_0400, 12);  // second command has no effect
        clear_log();
        drive_start(OP_COPY, 32'h0000_1000, 32'h0000_0400, 12, '0);
        repeat (3) @(posedge clk);
        #1;
        check_bit("busy", busy, 1'b1);
        drive_start(OP_FILL, 32'h0000_0000, 32'h0000_3800, 16, {4{32'hbad0_f111}});
        wait_done(cycles);
        beats_at_done = wr_beats_seen;
        repeat (5) begin
            @(posedge clk);
            #1;
            check_bit("busy", busy, 1'b0);
        end
        if (wr_beats_seen != beats_at_done)
            abort_run("write traffic after the first command finished");
        check_bursts(1'b1, 32'h0000_1000, 12);
        check_bursts(1'b0, 32'h0000_0400, 12);
        compare_mem();
    endtask

    initial begin
        void'($urandom(32'h3c31_fdba));
        stall_en  = 1'b0;
        cmd_start = 1'b0;
        cmd_op    = OP_COPY;
        cmd_src   = '0;
        cmd_dst   = '0;
        cmd_len   = '0;
        fill_data = '0;
        wait_reset();
        test_reset();
        test_single_copy();
        test_multi_copy();
        test_fill();
        test_zero_len();
        test_start_while_busy();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* filelist.f */
verilog/sdram_copy_pkg.sv
verilog/sdram_read.sv
verilog/sdram_write.sv
verilog/beat_fifo.sv
verilog/copy_ctrl.sv
verilog/sdram_copy_top.sv
testbench/tb_clk_gen.sv
testbench/avm_mem_model.sv
testbench/tb_sdram_copy.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, verdict from the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_sdram_copy -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
